// ==== mem_1r1w_top.f ====
logic/mem_pkg.sv
logic/bank_sram.sv
logic/bank_map.sv
logic/port_steer.sv
logic/mem_1r1w_top.sv
testbench/mem_1r1w_sva.sv
testbench/mem_1r1w_tb.sv

// ==== testbench/mem_1r1w_tb.sv ====
module mem_1r1w_tb
  import mem_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ADDR = 1 << $bits(addr_t);
  localparam int RAND_OPS = 2000;
  localparam int CONF_OPS = 500;
  localparam int SAME_OPS = 8;
  // cycle count of every test plus reset and drain cycles and some slack
  localparam int TOTAL_OPS = 5 * NUM_ADDR + RAND_OPS + CONF_OPS + 2 * SAME_OPS + 16;
  localparam int TIMEOUT_NS = TOTAL_OPS * 10 * 2;

  logic  clk;
  logic  rst;
  logic  read;
  addr_t rd_adr;
  logic  write;
  addr_t wr_adr;
  data_t din;
  logic  rd_vld;
  data_t rd_dout;

  // reference memory and the expected words of outstanding reads
  data_t model [NUM_ADDR];
  data_t exp_q [$];
  string test_name;

  mem_1r1w_top mem_1r1w_top_inst (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .rd_adr  (rd_adr),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  bind port_steer mem_1r1w_sva mem_1r1w_sva_inst (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .write    (write),
    .rd_pbank (rd_pbank),
    .wr_dest  (wr_dest),
    .bank_req (bank_req),
    .rd_vld   (rd_vld)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error: %s %s expected %h actual %h",
                                  test_name, what, expected, actual));
    end
  endtask

  // each cycle checks the result of the last read and then drives new strobes
  task automatic do_cycle(input logic rd_en, input addr_t ra, input logic wr_en,
                          input addr_t wa, input data_t d);
    @(negedge clk);
    check_value("rd_vld", exp_q.size() != 0, rd_vld);
    if (rd_vld) begin
      check_value("rd_dout", exp_q.pop_front(), rd_dout);
    end
    read   = rd_en;
    rd_adr = ra;
    write  = wr_en;
    wr_adr = wa;
    din    = d;
    // the read sees the word from before this cycle's write
    if (rd_en) begin
      exp_q.push_back(model[ra]);
    end
    if (wr_en) begin
      model[wa] = d;
    end
  endtask

  task automatic idle_cycle();
    do_cycle(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic read_back_all();
    for (int a = 0; a < NUM_ADDR; a++) begin
      do_cycle(1'b1, addr_t'(a), 1'b0, '0, '0);
    end
    idle_cycle();
  endtask

  task automatic apply_reset();
    test_name = "reset";
    rst = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_value("rd_vld", 1'b0, rd_vld);
    end
    rst = 1'b0;
  endtask

  task automatic fill_and_read();
    test_name = "fill_and_read";
    for (int a = 0; a < NUM_ADDR; a++) begin
      do_cycle(1'b0, '0, 1'b1, addr_t'(a), data_t'($urandom));
    end
    read_back_all();
  endtask

  task automatic random_traffic();
    test_name = "random_traffic";
    for (int i = 0; i < RAND_OPS; i++) begin
      do_cycle($urandom_range(0, 1), addr_t'($urandom),
               $urandom_range(0, 1), addr_t'($urandom), data_t'($urandom));
    end
    idle_cycle();
  endtask

  // same logical bank on both ports at different rows
  task automatic forced_conflicts();
    vbank_t vb;
    row_t   r_rd;
    row_t   r_wr;
    test_name = "forced_conflicts";
    for (int i = 0; i < CONF_OPS; i++) begin
      vb   = vbank_t'($urandom);
      r_rd = row_t'($urandom);
      r_wr = row_t'($urandom);
      if (r_wr == r_rd) begin
        r_wr = r_rd + 1'b1;
      end
      do_cycle(1'b1, addr_t'({vb, r_rd}), 1'b1, addr_t'({vb, r_wr}), data_t'($urandom));
    end
    read_back_all();
  endtask

  task automatic same_address();
    addr_t a;
    data_t d;
    test_name = "same_address";
    for (int i = 0; i < SAME_OPS; i++) begin
      a = addr_t'($urandom);
      d = ~model[a];
      do_cycle(1'b1, a, 1'b1, a, d);
      do_cycle(1'b1, a, 1'b0, '0, '0);
    end
    idle_cycle();
  endtask

  // every address is written once while a random row of its bank is read
  task automatic conflict_scan();
    addr_t  wa;
    vbank_t vb;
    test_name = "conflict_scan";
    for (int a = 0; a < NUM_ADDR; a++) begin
      wa = addr_t'(a);
      vb = vbank_t'(wa >> $bits(row_t));
      do_cycle(1'b1, addr_t'({vb, row_t'($urandom)}), 1'b1, wa, data_t'($urandom));
    end
    read_back_all();
  endtask

  initial begin
    #(TIMEOUT_NS);
    stop_with_failure($sformatf("timeout: the run did not finish within %0d ns",
                                TIMEOUT_NS));
  end

  initial begin
    void'($urandom(40));
    rst    = 1'b1;
    read   = 1'b0;
    rd_adr = '0;
    write  = 1'b0;
    wr_adr = '0;
    din    = '0;
    apply_reset();
    fill_and_read();
    random_traffic();
    forced_conflicts();
    same_address();
    conflict_scan();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== testbench/mem_1r1w_sva.sv ====
module mem_1r1w_sva
  import mem_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      read,
  input logic      write,
  input pbank_t    rd_pbank,
  input pbank_t    wr_dest,
  input bank_req_t bank_req [NUMPBNK],
  input logic      rd_vld
);

  timeunit 1ns;
  timeprecision 100ps;

  // a single-port bank takes one access per cycle
  for (genvar p = 0; p < NUMPBNK; p++) begin : g_bank_check
    one_access_per_bank: assert property (
      @(posedge clk) disable iff (rst)
      !(bank_req[p].read && bank_req[p].write)
    ) else $error("physical bank %0d got a read and a write in one cycle", p);
  end

  // rd_vld is the read strobe delayed by one cycle
  read_valid_delay: assert property (
    @(posedge clk) disable iff (rst)
    rd_vld == $past(read)
  ) else $error("rd_vld does not follow the read strobe of the previous cycle");

  // the write is steered away from the bank that serves the read
  write_avoids_read_bank: assert property (
    @(posedge clk) disable iff (rst)
    read && write |-> wr_dest != rd_pbank
  ) else $error("write sent to physical bank %0d which is being read", wr_dest);

endmodule

// ==== logic/mem_1r1w_top.sv ====
module mem_1r1w_top
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  // read port
  input  logic  read,
  input  addr_t rd_adr,

  // write port
  input  logic  write,
  input  addr_t wr_adr,
  input  data_t din,

  // read result one cycle after the read
  output logic  rd_vld,
  output data_t rd_dout
);

  // lookups between steering and the bank map
  vbank_t rd_vbank;
  vbank_t wr_vbank;
  row_t   rd_row;
  row_t   wr_row;
  pbank_t rd_pbank;
  pbank_t wr_pbank;
  pbank_t wr_free;
  logic   swap;

  // physical bank traffic
  bank_req_t bank_req  [NUMPBNK];
  data_t     bank_dout [NUMPBNK];

  port_steer port_steer_inst (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .rd_adr    (rd_adr),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .rd_pbank  (rd_pbank),
    .wr_pbank  (wr_pbank),
    .wr_free   (wr_free),
    .rd_vbank  (rd_vbank),
    .wr_vbank  (wr_vbank),
    .rd_row    (rd_row),
    .wr_row    (wr_row),
    .swap      (swap),
    .bank_req  (bank_req),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

  bank_map bank_map_inst (
    .clk      (clk),
    .rst      (rst),
    .rd_vbank (rd_vbank),
    .rd_row   (rd_row),
    .wr_vbank (wr_vbank),
    .wr_row   (wr_row),
    .swap     (swap),
    .rd_pbank (rd_pbank),
    .wr_pbank (wr_pbank),
    .wr_free  (wr_free)
  );

  // the logical banks plus the spare, all alike
  for (genvar i = 0; i < NUMPBNK; i++) begin : g_bank
    bank_sram bank_sram_inst (
      .clk  (clk),
      .req  (bank_req[i]),
      .dout (bank_dout[i])
    );
  end

endmodule

// ==== logic/port_steer.sv ====
module port_steer
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // outside read port
  input  logic      read,
  input  addr_t     rd_adr,

  // outside write port
  input  logic      write,
  input  addr_t     wr_adr,
  input  data_t     din,

  // answers from the bank map
  input  pbank_t    rd_pbank,
  input  pbank_t    wr_pbank,
  input  pbank_t    wr_free,

  // lookups and swap strobe to the bank map
  output vbank_t    rd_vbank,
  output vbank_t    wr_vbank,
  output row_t      rd_row,
  output row_t      wr_row,
  output logic      swap,

  // physical bank ports
  output bank_req_t bank_req [NUMPBNK],
  input  data_t     bank_dout [NUMPBNK],

  // read result
  output logic      rd_vld,
  output data_t     rd_dout
);

  // physical bank the write actually goes to
  pbank_t wr_dest;

  // bank that served the read in the previous cycle
  pbank_t rd_sel;
  logic   rd_vld_q;

  // split the addresses into logical bank and row
  assign rd_vbank = rd_adr[BITADDR-1 -: BITVBNK];
  assign rd_row   = rd_adr[BITVROW-1:0];
  assign wr_vbank = wr_adr[BITADDR-1 -: BITVBNK];
  assign wr_row   = wr_adr[BITVROW-1:0];

  // a write collides with the read when both map to the same physical bank
  // rows may differ since a single-port bank takes only one access anyway
  assign swap = read && write && (wr_pbank == rd_pbank);

  // on a collision the write moves to the free slot of its row
  // that slot is never wr_pbank, so it cannot be the read bank either
  assign wr_dest = swap ? wr_free : wr_pbank;

  // build one request per physical bank
  always_comb begin
    for (int p = 0; p < NUMPBNK; p++) begin
      bank_req[p].read  = read && (rd_pbank == pbank_t'(p));
      bank_req[p].write = write && (wr_dest == pbank_t'(p));
      bank_req[p].data  = din;
      if (bank_req[p].read) begin
        bank_req[p].row = rd_row;
      end else begin
        bank_req[p].row = wr_row;
      end
    end
  end

  // read valid follows the read strobe by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= read;
    end
  end

  // remember which bank holds the read word for the output mux
  always_ff @(posedge clk) begin
    if (read) begin
      rd_sel <= rd_pbank;
    end
  end

  assign rd_vld  = rd_vld_q;
  assign rd_dout = bank_dout[rd_sel];

endmodule

// ==== logic/bank_map.sv ====
module bank_map
  import mem_pkg::*;
(
  input  logic   clk,
  input  logic   rst,

  // read side lookup
  input  vbank_t rd_vbank,
  input  row_t   rd_row,

  // write side lookup
  input  vbank_t wr_vbank,
  input  row_t   wr_row,

  // exchange the written bank's slot with the free slot of wr_row
  input  logic   swap,

  output pbank_t rd_pbank,
  output pbank_t wr_pbank,
  output pbank_t wr_free
);

  // one entry per row with a slot per logical bank and the spare slot
  row_map_t map_mem [NUMVROW];

  // entries addressed by the two ports
  row_map_t rd_entry;
  row_map_t wr_entry;

  // the lookup is combinational from the table registers
  always_comb begin
    rd_entry = map_mem[rd_row];
    wr_entry = map_mem[wr_row];
  end

  assign rd_pbank = rd_entry.slot[rd_vbank];
  assign wr_pbank = wr_entry.slot[wr_vbank];
  assign wr_free  = wr_entry.free_slot;

  // reset puts every row back to the identity map
  // logical bank k lives in physical bank k and the spare bank is free
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUMVROW; r++) begin
        for (int k = 0; k < NUMVBNK; k++) begin
          map_mem[r].slot[k] <= pbank_t'(k);
        end
        map_mem[r].free_slot <= pbank_t'(NUMVBNK);
      end
    end else if (swap) begin
      // the written word now lives in the old free slot
      map_mem[wr_row].slot[wr_vbank] <= wr_free;
      // and the slot it left behind holds stale data, so it becomes free
      map_mem[wr_row].free_slot      <= wr_pbank;
    end
  end

endmodule

// ==== logic/bank_sram.sv ====
module bank_sram
  import mem_pkg::*;
(
  input  logic      clk,
  input  bank_req_t req,
  output data_t     dout
);

  // storage array of one physical bank
  data_t mem [NUMVROW];

  // read data register
  // it only loads on a read so the last word stays on dout otherwise
  data_t dout_q;

  // write lands at the clock edge
  always_ff @(posedge clk) begin
    if (req.write) begin
      mem[req.row] <= req.data;
    end
  end

  // registered read with one cycle of latency
  always_ff @(posedge clk) begin
    if (req.read) begin
      dout_q <= mem[req.row];
    end
  end

  assign dout = dout_q;

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

  // data word width in bits
  localparam int WIDTH = 16;

  // logical banks seen by the address decode
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;

  // physical banks hold every logical bank plus one spare per row
  localparam int NUMPBNK = NUMVBNK + 1;
  localparam int BITPBNK = 3;

  // rows in each bank
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;

  // the logical bank index sits above the row index in an address
  localparam int BITADDR = BITVBNK + BITVROW;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [BITVROW-1:0] row_t;
  typedef logic [BITVBNK-1:0] vbank_t;
  typedef logic [BITPBNK-1:0] pbank_t;
  typedef logic [BITADDR-1:0] addr_t;

  // one access to a single-port bank
  // at most one of read and write is set in any cycle
  typedef struct packed {
    logic  read;
    logic  write;
    row_t  row;
    data_t data;
  } bank_req_t;

  // row entry of the bank map
  // slot holds the physical bank of each logical bank and free_slot
  // names the one physical bank that holds no live word in this row
  typedef struct packed {
    pbank_t                   free_slot;
    pbank_t [NUMVBNK-1:0]     slot;
  } row_map_t;

endpackage
